// ==== build.f ====
+incdir+design
design/audio_pkg.sv
design/tone_sequencer.sv
design/codec_i2c_config.sv
design/dac_serializer.sv
design/audio_control.sv
design/audio_top.sv
tests/audio_tb.sv

// ==== design/audio_config.svh ====
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// Sequencer step period in CLOCK_50 cycles
`define AUDIO_STEP_TICKS 5000

// Serial audio clocks, CLOCK_50 cycles per period
`define AUDIO_BCLK_DIV 4
`define AUDIO_XCK_DIV 4

// I2C bit is four quarters
`define I2C_QUARTER_TICKS 125
`define CODEC_I2C_ADDR 8'h34
`define CODEC_TABLE_LEN 10

// Active low segments, all off
`define SEG_BLANK 7'h7f

`endif

// ==== design/audio_control.sv ====
`include "audio_config.svh"

module audio_control (
    input  logic                   CLOCK_50,
    input  logic                   rst_n,
    input  logic [17:0]            SW,
    input  audio_pkg::seq_status_t seq_status,
    input  audio_pkg::cfg_status_t cfg_status,
    input  audio_pkg::sample_t     sample,
    output logic                   run_en,
    output audio_pkg::sample_t     play_sample,
    output logic [6:0]             HEX0,
    output logic [6:0]             HEX1,
    output logic [6:0]             HEX2,
    output logic [6:0]             HEX3
);

    localparam logic [6:0] SEG_D = 7'h21;
    localparam logic [6:0] SEG_E = 7'h06;

    logic [1:0] play_sync;
    logic [1:0] mute_sync;
    logic [4:0] disp_step;
    logic [3:0] disp_words;
    logic       disp_done;
    logic       disp_nack;

    function automatic logic [6:0] seg7(input logic [3:0] value);
        logic [6:0] seg;
        case (value)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'ha: seg = 7'h08;
            4'hb: seg = 7'h03;
            4'hc: seg = 7'h46;
            4'hd: seg = 7'h21;
            4'he: seg = 7'h06;
            default: seg = 7'h0e;
        endcase
        return seg;
    endfunction

    // SW[17] plays, SW[0] mutes
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            play_sync <= '0;
            mute_sync <= '0;
        end else begin
            play_sync <= {play_sync[0], SW[17]};
            mute_sync <= {mute_sync[0], SW[0]};
        end
    end

    // Nothing plays until the codec table is written
    assign run_en      = cfg_status.done & play_sync[1];
    assign play_sample = (cfg_status.done && !mute_sync[1]) ? sample : '0;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            disp_step  <= '0;
            disp_words <= '0;
            disp_done  <= 1'b0;
            disp_nack  <= 1'b0;
        end else begin
            if (seq_status.step_strobe) begin
                disp_step <= seq_status.step_index;
            end
            disp_words <= cfg_status.words_written;
            disp_done  <= cfg_status.done;
            disp_nack  <= cfg_status.nack_seen;
        end
    end

    assign HEX0 = seg7(disp_step[3:0]);
    assign HEX1 = seg7({3'b000, disp_step[4]});
    assign HEX2 = seg7(disp_words);
    assign HEX3 = disp_done ? SEG_D : (disp_nack ? SEG_E : `SEG_BLANK);

endmodule

// ==== design/audio_pkg.sv ====
package audio_pkg;

    typedef struct packed {
        logic [6:0] addr;
        logic [8:0] data;
    } codec_reg_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } codec_bytes_t;

    // Same 16 bits seen as a codec register write or as two I2C bytes
    typedef union packed {
        codec_reg_t   reg_view;
        codec_bytes_t byte_view;
    } codec_word_t;

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        logic [4:0] step_index;
        logic       step_strobe;
    } seq_status_t;

    typedef struct packed {
        logic       done;
        logic       nack_seen;
        logic [3:0] words_written;
    } cfg_status_t;

    function automatic codec_word_t codec_init_word(input logic [3:0] idx);
        codec_word_t word;
        case (idx)
            4'd0:    word.reg_view = '{addr: 7'h0f, data: 9'h000};
            4'd1:    word.reg_view = '{addr: 7'h00, data: 9'h080};
            4'd2:    word.reg_view = '{addr: 7'h02, data: 9'h079};
            4'd3:    word.reg_view = '{addr: 7'h04, data: 9'h012};
            4'd4:    word.reg_view = '{addr: 7'h05, data: 9'h000};
            4'd5:    word.reg_view = '{addr: 7'h06, data: 9'h000};
            // Left-justified, 16 bit, codec as clock slave
            4'd6:    word.reg_view = '{addr: 7'h07, data: 9'h001};
            4'd7:    word.reg_view = '{addr: 7'h08, data: 9'h000};
            default: word.reg_view = '{addr: 7'h09, data: 9'h001};
        endcase
        return word;
    endfunction

endpackage

// ==== design/audio_top.sv ====
`include "audio_config.svh"

module audio_top (
    input  logic        CLOCK_50,
    input  logic [3:0]  KEY,
    input  logic [17:0] SW,
    // ADC path is not used
    input  logic        AUD_ADCDAT,
    output logic [6:0]  HEX0,
    output logic [6:0]  HEX1,
    output logic [6:0]  HEX2,
    output logic [6:0]  HEX3,
    output logic [6:0]  HEX4,
    output logic [6:0]  HEX5,
    output logic [6:0]  HEX6,
    output logic [6:0]  HEX7,
    output logic        AUD_DACDAT,
    output logic        AUD_DACLRCK,
    output logic        AUD_BCLK,
    output logic        AUD_XCK,
    output logic        I2C_SCLK,
    inout  wire         I2C_SDAT
);

    logic                   rst_n;
    logic                   run_en;
    audio_pkg::seq_status_t seq_status;
    audio_pkg::cfg_status_t cfg_status;
    audio_pkg::sample_t     sample;
    audio_pkg::sample_t     play_sample;

    assign rst_n = KEY[3];

    assign HEX4 = `SEG_BLANK;
    assign HEX5 = `SEG_BLANK;
    assign HEX6 = `SEG_BLANK;
    assign HEX7 = `SEG_BLANK;

    audio_control u_control (
        .CLOCK_50    (CLOCK_50),
        .rst_n       (rst_n),
        .SW          (SW),
        .seq_status  (seq_status),
        .cfg_status  (cfg_status),
        .sample      (sample),
        .run_en      (run_en),
        .play_sample (play_sample),
        .HEX0        (HEX0),
        .HEX1        (HEX1),
        .HEX2        (HEX2),
        .HEX3        (HEX3)
    );

    tone_sequencer u_sequencer (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .run_en   (run_en),
        .sample   (sample),
        .status   (seq_status)
    );

    codec_i2c_config u_codec_cfg (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .I2C_SCLK (I2C_SCLK),
        .I2C_SDAT (I2C_SDAT),
        .status   (cfg_status)
    );

    dac_serializer u_serializer (
        .CLOCK_50    (CLOCK_50),
        .rst_n       (rst_n),
        .play_sample (play_sample),
        .AUD_XCK     (AUD_XCK),
        .AUD_BCLK    (AUD_BCLK),
        .AUD_DACLRCK (AUD_DACLRCK),
        .AUD_DACDAT  (AUD_DACDAT)
    );

endmodule

// ==== design/codec_i2c_config.sv ====
`include "audio_config.svh"

module codec_i2c_config (
    input  logic                   CLOCK_50,
    input  logic                   rst_n,
    output logic                   I2C_SCLK,
    inout  wire                    I2C_SDAT,
    output audio_pkg::cfg_status_t status
);

    localparam int Q_W = $clog2(`I2C_QUARTER_TICKS);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_BYTE,
        ST_ACK,
        ST_STOP,
        ST_NEXT,
        ST_DONE
    } state_t;

    state_t                 state;
    logic [Q_W-1:0]         q_cnt;
    logic                   q_tick;
    logic [1:0]             phase;
    logic [2:0]             bit_cnt;
    logic [1:0]             byte_sel;
    logic [7:0]             tx_byte;
    logic [3:0]             word_idx;
    logic                   word_fail;
    logic                   sda_low;
    logic [1:0]             sda_sync;
    logic                   done;
    logic                   nack_seen;
    logic [3:0]             words_written;
    audio_pkg::codec_word_t cur_word;

    assign cur_word = audio_pkg::codec_init_word(word_idx);
    assign q_tick   = (q_cnt == Q_W'(`I2C_QUARTER_TICKS - 1));

    // Open drain, only ever pulls low
    assign I2C_SDAT = sda_low ? 1'b0 : 1'bz;

    assign status = '{done: done, nack_seen: nack_seen, words_written: words_written};

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            q_cnt    <= '0;
            sda_sync <= 2'b11;
        end else begin
            q_cnt    <= q_tick ? '0 : q_cnt + 1'b1;
            sda_sync <= {sda_sync[0], I2C_SDAT};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            phase         <= '0;
            bit_cnt       <= '0;
            byte_sel      <= '0;
            tx_byte       <= `CODEC_I2C_ADDR;
            word_idx      <= '0;
            word_fail     <= 1'b0;
            I2C_SCLK      <= 1'b1;
            sda_low       <= 1'b0;
            done          <= 1'b0;
            nack_seen     <= 1'b0;
            words_written <= '0;
        end else if (q_tick) begin
            phase <= phase + 1'b1;
            case (state)
                ST_IDLE: begin
                    // Start condition, SDA falls while SCL is high
                    sda_low <= 1'b1;
                    phase   <= 2'd1;
                    state   <= ST_START;
                end
                ST_START: begin
                    if (phase == 2'd3) begin
                        I2C_SCLK  <= 1'b0;
                        byte_sel  <= '0;
                        word_fail <= 1'b0;
                        state     <= ST_BYTE;
                    end
                end
                ST_BYTE: begin
                    case (phase)
                        2'd0: sda_low <= ~tx_byte[7];
                        2'd1: I2C_SCLK <= 1'b1;
                        2'd3: begin
                            I2C_SCLK <= 1'b0;
                            tx_byte  <= {tx_byte[6:0], 1'b0};
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= ST_ACK;
                            end
                        end
                        default: ;
                    endcase
                end
                ST_ACK: begin
                    case (phase)
                        2'd0: sda_low <= 1'b0;
                        2'd1: I2C_SCLK <= 1'b1;
                        2'd2: begin
                            if (sda_sync[1]) begin
                                word_fail <= 1'b1;
                                nack_seen <= 1'b1;
                            end
                        end
                        default: begin
                            I2C_SCLK <= 1'b0;
                            if (word_fail || byte_sel == 2'd2) begin
                                state <= ST_STOP;
                            end else begin
                                tx_byte  <= (byte_sel == 2'd0) ? cur_word.byte_view.hi
                                                               : cur_word.byte_view.lo;
                                byte_sel <= byte_sel + 1'b1;
                                state    <= ST_BYTE;
                            end
                        end
                    endcase
                end
                ST_STOP: begin
                    case (phase)
                        2'd0: sda_low <= 1'b1;
                        2'd1: I2C_SCLK <= 1'b1;
                        2'd2: sda_low <= 1'b0;
                        default: state <= ST_NEXT;
                    endcase
                end
                ST_NEXT: begin
                    phase   <= '0;
                    tx_byte <= `CODEC_I2C_ADDR;
                    state   <= ST_IDLE;
                    // A failed word goes out again unchanged
                    if (!word_fail) begin
                        words_written <= words_written + 1'b1;
                        if (word_idx == 4'(`CODEC_TABLE_LEN - 1)) begin
                            state <= ST_DONE;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    phase <= '0;
                    done  <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== design/dac_serializer.sv ====
`include "audio_config.svh"

module dac_serializer (
    input  logic               CLOCK_50,
    input  logic               rst_n,
    input  audio_pkg::sample_t play_sample,
    output logic               AUD_XCK,
    output logic               AUD_BCLK,
    output logic               AUD_DACLRCK,
    output logic               AUD_DACDAT
);

    localparam int XCK_W  = $clog2(`AUDIO_XCK_DIV);
    localparam int BCLK_W = $clog2(`AUDIO_BCLK_DIV);

    logic [XCK_W-1:0]   xck_cnt;
    logic [BCLK_W-1:0]  bclk_cnt;
    logic               bit_edge;
    logic [4:0]         bit_cnt;
    audio_pkg::sample_t frame_word;
    audio_pkg::sample_t shift_reg;

    // Last cycle of BCLK high, next edge is the falling one
    assign bit_edge = (bclk_cnt == BCLK_W'(`AUDIO_BCLK_DIV - 1));

    assign AUD_XCK     = xck_cnt[XCK_W-1];
    assign AUD_BCLK    = bclk_cnt[BCLK_W-1];
    assign AUD_DACLRCK = ~bit_cnt[4];
    assign AUD_DACDAT  = shift_reg[15];

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            xck_cnt  <= '0;
            bclk_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (xck_cnt == XCK_W'(`AUDIO_XCK_DIV - 1)) begin
                xck_cnt <= '0;
            end else begin
                xck_cnt <= xck_cnt + 1'b1;
            end
            bclk_cnt <= bit_edge ? '0 : bclk_cnt + 1'b1;
            if (bit_edge) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            frame_word <= '0;
            shift_reg  <= '0;
        end else if (bit_edge) begin
            if (bit_cnt == 5'd31) begin
                // Frame start, LRCK rises
                frame_word <= play_sample;
                shift_reg  <= play_sample;
            end else if (bit_cnt == 5'd15) begin
                // Right channel repeats the left word
                shift_reg <= frame_word;
            end else begin
                shift_reg <= {shift_reg[14:0], 1'b0};
            end
        end
    end

endmodule

// ==== design/tone_sequencer.sv ====
`include "audio_config.svh"

module tone_sequencer (
    input  logic                   CLOCK_50,
    input  logic                   rst_n,
    input  logic                   run_en,
    output audio_pkg::sample_t     sample,
    output audio_pkg::seq_status_t status
);

    localparam int TICK_W = $clog2(`AUDIO_STEP_TICKS);

    logic [TICK_W-1:0] tick_cnt;
    logic              step_due;
    logic [4:0]        step_index;
    logic              step_strobe;
    logic [3:0]        level;

    assign step_due = (tick_cnt == TICK_W'(`AUDIO_STEP_TICKS - 1));

    // Triangle: down from F in the first half, up from 0 in the second
    assign level = step_index[4] ? step_index[3:0] : ~step_index[3:0];

    assign status = '{step_index: step_index, step_strobe: step_strobe};

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt    <= '0;
            step_index  <= '0;
            step_strobe <= 1'b0;
        end else begin
            step_strobe <= 1'b0;
            if (run_en) begin
                if (step_due) begin
                    tick_cnt    <= '0;
                    step_index  <= step_index + 1'b1;
                    step_strobe <= 1'b1;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    // Level lands on bits 13:10
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            sample <= '0;
        end else begin
            sample <= {2'b00, level, 10'b0};
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run; pass only if the pass message appears
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module audio_tb -o audio_sim \
    && ./obj_dir/audio_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tests/audio_tb.sv ====
`include "audio_config.svh"

module audio_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int M_WAIT = 0;
    localparam int M_PLAY = 1;
    localparam int M_MUTE = 2;
    localparam int M_HOLD = 3;
    localparam logic [6:0] SEG_D = 7'h21;
    localparam logic [6:0] SEG_A = 7'h08;
    localparam logic [6:0] SEG_OFF = 7'h7f;
    localparam int BIT_CLKS = 4 * `I2C_QUARTER_TICKS;
    localparam int WATCHDOG_CYCLES = 11 * 30 * BIT_CLKS + 80 * `AUDIO_STEP_TICKS;

    logic        CLOCK_50;
    logic [3:0]  KEY;
    logic [17:0] SW;
    logic        AUD_ADCDAT;
    logic [6:0]  HEX0;
    logic [6:0]  HEX1;
    logic [6:0]  HEX2;
    logic [6:0]  HEX3;
    logic [6:0]  HEX4;
    logic [6:0]  HEX5;
    logic [6:0]  HEX6;
    logic [6:0]  HEX7;
    logic        AUD_DACDAT;
    logic        AUD_DACLRCK;
    logic        AUD_BCLK;
    logic        AUD_XCK;
    logic        I2C_SCLK;
    wire         I2C_SDAT;

    logic        slave_low;
    int          errors;
    int          mode;
    int          settle;
    int          mute_frames;
    int          k;
    int          hold_k;
    int          words_acked;
    int          transactions;
    int          nacks_sent;
    int          xck_periods;
    logic        last_lrck;
    logic [15:0] shift_w;
    logic [15:0] left_w;
    logic [15:0] right_w;
    logic [6:0]  hex0_held;
    logic [6:0]  hex1_held;

    pullup (I2C_SDAT);
    assign I2C_SDAT = slave_low ? 1'b0 : 1'bz;

    audio_top DUT (
        .CLOCK_50    (CLOCK_50),
        .KEY         (KEY),
        .SW          (SW),
        .AUD_ADCDAT  (AUD_ADCDAT),
        .HEX0        (HEX0),
        .HEX1        (HEX1),
        .HEX2        (HEX2),
        .HEX3        (HEX3),
        .HEX4        (HEX4),
        .HEX5        (HEX5),
        .HEX6        (HEX6),
        .HEX7        (HEX7),
        .AUD_DACDAT  (AUD_DACDAT),
        .AUD_DACLRCK (AUD_DACLRCK),
        .AUD_BCLK    (AUD_BCLK),
        .AUD_XCK     (AUD_XCK),
        .I2C_SCLK    (I2C_SCLK),
        .I2C_SDAT    (I2C_SDAT)
    );

    // Codec register writes as {7-bit address, 9-bit data}
    function automatic logic [15:0] expected_word(input int i);
        logic [15:0] word;
        case (i)
            0: word = {7'h0f, 9'h000};
            1: word = {7'h00, 9'h080};
            2: word = {7'h02, 9'h079};
            3: word = {7'h04, 9'h012};
            4: word = {7'h05, 9'h000};
            5: word = {7'h06, 9'h000};
            6: word = {7'h07, 9'h001};
            7: word = {7'h08, 9'h000};
            default: word = {7'h09, 9'h001};
        endcase
        return word;
    endfunction

    // Triangle runs from F down to 0 and back up to F
    function automatic int expected_level(input int step);
        return (step < 16) ? (15 - step) : (step - 16);
    endfunction

    // Level sits on bits 13:10 of the sample
    function automatic logic [15:0] expected_sample(input int step);
        return 16'(expected_level(step)) << 10;
    endfunction

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Accepts the same step or the next one
    // Steps 15 and 16 share a level as do 31 and 0
    task automatic track_step(input logic [15:0] val);
        logic [15:0] e0;
        logic [15:0] e1;
        logic [15:0] e2;
        e0 = expected_sample(k);
        e1 = expected_sample((k + 1) % 32);
        e2 = expected_sample((k + 2) % 32);
        if (val == e0) begin
        end else if (val == e1) begin
            k = (k + 1) % 32;
        end else if (e0 == e1 && val == e2) begin
            k = (k + 2) % 32;
        end else begin
            check_value("left_sample", 32'(val), 32'(e1));
        end
    endtask

    task automatic check_frame(input logic [15:0] l, input logic [15:0] r);
        case (mode)
            M_WAIT: begin
                check_value("left_sample", 32'(l), 32'h0);
                check_value("right_sample", 32'(r), 32'h0);
            end
            M_MUTE: begin
                mute_frames++;
                if (mute_frames >= 3) begin
                    check_value("left_sample", 32'(l), 32'h0);
                    check_value("right_sample", 32'(r), 32'h0);
                end
            end
            default: begin
                check_value("right_sample", 32'(r), 32'(l));
                if (settle > 0) begin
                    settle--;
                    if (l != 16'h0) begin
                        track_step(l);
                    end
                    hold_k = k;
                end else if (mode == M_HOLD) begin
                    check_value("left_sample", 32'(l), 32'(expected_sample(hold_k)));
                end else begin
                    track_step(l);
                end
            end
        endcase
    endtask

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // Frame decoder takes one bit per rising BCLK
    initial begin
        last_lrck = 1'b1;
        shift_w   = '0;
        forever begin
            @(posedge AUD_BCLK);
            if (AUD_DACLRCK != last_lrck) begin
                if (last_lrck) begin
                    left_w = shift_w;
                end else begin
                    right_w = shift_w;
                    check_frame(left_w, right_w);
                end
                shift_w = '0;
            end
            shift_w   = {shift_w[14:0], AUD_DACDAT};
            last_lrck = AUD_DACLRCK;
        end
    end

    // Codec master clock runs at CLOCK_50 divided by AUDIO_XCK_DIV
    initial begin
        logic xck_prev;
        int   clks;
        xck_prev    = 1'b0;
        clks        = -1;
        xck_periods = 0;
        forever begin
            @(posedge CLOCK_50);
            if (clks >= 0) begin
                clks++;
            end
            if (AUD_XCK === 1'b1 && xck_prev !== 1'b1) begin
                if (clks >= 0) begin
                    check_value("AUD_XCK_period", 32'(clks), 32'(`AUDIO_XCK_DIV));
                    xck_periods++;
                end
                clks = 0;
            end
            xck_prev = AUD_XCK;
        end
    end

    // I2C slave that nacks the low byte of one word once if the flag is set
    initial begin
        int unsigned seed;
        logic        nack_en;
        int          nack_word;
        logic        nacked;
        logic [7:0]  rx;
        logic [7:0]  exp_byte;
        slave_low    = 1'b0;
        words_acked  = 0;
        transactions = 0;
        nacks_sent   = 0;
        seed      = lcg_next(32'd47152);
        nack_en   = seed[16];
        seed      = lcg_next(seed);
        nack_word = int'((seed >> 16) % 10);
        forever begin
            do @(negedge I2C_SDAT); while (I2C_SCLK !== 1'b1);
            transactions++;
            nacked = 1'b0;
            for (int b = 0; b < 3 && !nacked; b++) begin
                for (int n = 0; n < 8; n++) begin
                    @(posedge I2C_SCLK);
                    rx = {rx[6:0], I2C_SDAT};
                end
                if (b == 0) begin
                    exp_byte = `CODEC_I2C_ADDR;
                end else if (b == 1) begin
                    exp_byte = 8'(expected_word(words_acked) >> 8);
                end else begin
                    exp_byte = 8'(expected_word(words_acked));
                end
                check_value("i2c_byte", 32'(rx), 32'(exp_byte));
                if (HEX3 == SEG_D) begin
                    errors++;
                    $display("HEX3 shows done while the codec table is still being written");
                end
                @(negedge I2C_SCLK);
                if (b == 2 && nack_en && nacks_sent == 0 && words_acked == nack_word) begin
                    nacked = 1'b1;
                    nacks_sent++;
                end else begin
                    slave_low <= 1'b1;
                end
                @(negedge I2C_SCLK);
                slave_low <= 1'b0;
            end
            if (!nacked) begin
                words_acked++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        errors     = 0;
        mode       = M_WAIT;
        settle     = 0;
        k          = 0;
        hold_k     = 0;
        KEY        = 4'h7;
        SW         = '0;
        SW[17]     = 1'b1;
        AUD_ADCDAT = 1'b0;
        repeat (8) @(posedge CLOCK_50);
        KEY <= 4'hf;

        wait (words_acked == `CODEC_TABLE_LEN);
        while (HEX3 != SEG_D) @(posedge CLOCK_50);
        mode   = M_PLAY;
        settle = 3;
        check_value("HEX2", 32'(HEX2), 32'(SEG_A));
        check_value("i2c_transactions", 32'(transactions), 32'(`CODEC_TABLE_LEN + nacks_sent));
        check_value("HEX4", 32'(HEX4), 32'(SEG_OFF));
        check_value("HEX5", 32'(HEX5), 32'(SEG_OFF));
        check_value("HEX6", 32'(HEX6), 32'(SEG_OFF));
        check_value("HEX7", 32'(HEX7), 32'(SEG_OFF));

        repeat (6 * `AUDIO_STEP_TICKS) @(posedge CLOCK_50);
        SW[0] <= 1'b1;
        mute_frames = 0;
        mode        = M_MUTE;
        repeat (8 * 128) @(posedge CLOCK_50);
        SW[0] <= 1'b0;
        settle = 3;
        mode   = M_PLAY;

        repeat (3 * `AUDIO_STEP_TICKS) @(posedge CLOCK_50);
        SW[17] <= 1'b0;
        settle = 3;
        mode   = M_HOLD;
        repeat (4 * 128) @(posedge CLOCK_50);
        hex0_held = HEX0;
        hex1_held = HEX1;
        repeat (3 * `AUDIO_STEP_TICKS) @(posedge CLOCK_50);
        check_value("HEX0", 32'(HEX0), 32'(hex0_held));
        check_value("HEX1", 32'(HEX1), 32'(hex1_held));

        SW[17] <= 1'b1;
        mode = M_PLAY;
        repeat (3 * `AUDIO_STEP_TICKS) @(posedge CLOCK_50);
        if (k == hold_k) begin
            errors++;
            $display("The sequence did not advance after play was switched on again");
        end
        if (xck_periods == 0) begin
            errors++;
            $display("AUD_XCK never toggled");
        end

        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
